//--- src/aon_pkg.sv
`default_nettype none

package aon_pkg;

  // Bus widths
  localparam int AW    = 15;
  localparam int DW    = 32;
  localparam int OFS_W = 8;   // Register offset bits seen by a target

  // Address map, the low-clock generator owns one 256-byte region
  localparam logic [AW-1:0] LCLKGEN_BASE       = 15'h200;
  localparam int            LCLKGEN_REGION_LSB = 8;

  // Low-clock generator registers
  localparam logic [OFS_W-1:0] LFXOSCCFG_OFS = 8'h00;
  localparam int               LFXOSCEN_BIT  = 30;
  localparam logic             LFXOSCEN_RST  = 1'b1;  // Oscillator runs out of reset

  // RTC registers
  localparam logic [OFS_W-1:0] RTC_CTRL_OFS  = 8'h40;
  localparam logic [OFS_W-1:0] RTC_COUNT_OFS = 8'h48;
  localparam logic [OFS_W-1:0] RTC_CMP_OFS   = 8'h50;
  localparam logic [OFS_W-1:0] RTC_IP_OFS    = 8'h58;
  localparam int               RTC_EN_BIT    = 0;
  localparam int               RTC_IP_BIT    = 0;
  // Compare parked at all ones so a counter sitting at zero raises nothing
  localparam logic [DW-1:0]    RTC_CMP_RST   = '1;

  // Splitter FSM
  typedef enum logic [1:0] {
    IDLE,
    WAIT_LCLK,
    WAIT_RTC
  } split_state_e;

  typedef enum logic {
    OP_WRITE,
    OP_READ
  } bus_op_e;

endpackage

`default_nettype wire

//--- src/aon_icb_iso_slice.sv
`timescale 1ns/1ns
`default_nettype none

module aon_icb_iso_slice (
  input  wire                     clk,
  input  wire                     i_rst_n,
  input  wire                     i_aon_iso,
  input  wire                     i_cmd_valid,
  output logic                    o_cmd_ready,
  input  wire  [aon_pkg::AW-1:0]  i_cmd_addr,
  input  wire                     i_cmd_read,
  input  wire  [aon_pkg::DW-1:0]  i_cmd_wdata,
  input  wire                     i_rsp_ready,
  output logic                    o_slc_cmd_valid,
  input  wire                     i_slc_cmd_ready,
  output logic [aon_pkg::AW-1:0]  o_slc_cmd_addr,
  output logic                    o_slc_cmd_read,
  output logic [aon_pkg::DW-1:0]  o_slc_cmd_wdata,
  output logic                    o_slc_rsp_ready
);

  logic                   iso_cmd_valid;
  logic [aon_pkg::AW-1:0] iso_cmd_addr;
  logic                   iso_cmd_read;
  logic [aon_pkg::DW-1:0] iso_cmd_wdata;
  logic                   slc_full_q;
  logic                   slc_load;
  logic                   slc_drain;

  // Clamp everything the host drives, it may be powered down
  assign iso_cmd_valid   = i_aon_iso ? 1'b0 : i_cmd_valid;
  assign iso_cmd_addr    = i_aon_iso ? '0   : i_cmd_addr;
  assign iso_cmd_read    = i_aon_iso ? 1'b0 : i_cmd_read;
  assign iso_cmd_wdata   = i_aon_iso ? '0   : i_cmd_wdata;
  assign o_slc_rsp_ready = i_aon_iso ? 1'b0 : i_rsp_ready;

  assign slc_drain   = slc_full_q & i_slc_cmd_ready;
  assign o_cmd_ready = ~slc_full_q | slc_drain;
  assign slc_load    = iso_cmd_valid & o_cmd_ready;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      slc_full_q <= 1'b0;
    end else if (slc_load) begin
      slc_full_q <= 1'b1;
    end else if (slc_drain) begin
      slc_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (slc_load) begin
      o_slc_cmd_addr  <= iso_cmd_addr;
      o_slc_cmd_read  <= iso_cmd_read;
      o_slc_cmd_wdata <= iso_cmd_wdata;
    end
  end

  assign o_slc_cmd_valid = slc_full_q;

  // Command held in the slice must not change while the splitter stalls it
  a_slc_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    (slc_full_q && !i_slc_cmd_ready) |=> (slc_full_q && $stable(o_slc_cmd_addr)
      && $stable(o_slc_cmd_read) && $stable(o_slc_cmd_wdata)));

endmodule

`default_nettype wire

//--- src/aon_icb_split.sv
`timescale 1ns/1ns
`default_nettype none

module aon_icb_split (
  input  wire                        clk,
  input  wire                        i_rst_n,
  // From the iso slice
  input  wire                        i_cmd_valid,
  output logic                       o_cmd_ready,
  input  wire  [aon_pkg::AW-1:0]     i_cmd_addr,
  input  wire                        i_cmd_read,
  input  wire  [aon_pkg::DW-1:0]     i_cmd_wdata,
  output logic                       o_rsp_valid,
  input  wire                        i_rsp_ready,
  output logic [aon_pkg::DW-1:0]     o_rsp_rdata,
  // Low-clock generator target
  output logic                       o_lclk_cmd_valid,
  input  wire                        i_lclk_cmd_ready,
  output logic [aon_pkg::OFS_W-1:0]  o_lclk_cmd_addr,
  output logic                       o_lclk_cmd_read,
  output logic [aon_pkg::DW-1:0]     o_lclk_cmd_wdata,
  input  wire                        i_lclk_rsp_valid,
  output logic                       o_lclk_rsp_ready,
  input  wire  [aon_pkg::DW-1:0]     i_lclk_rsp_rdata,
  // RTC target
  output logic                       o_rtc_cmd_valid,
  input  wire                        i_rtc_cmd_ready,
  output logic [aon_pkg::OFS_W-1:0]  o_rtc_cmd_addr,
  output logic                       o_rtc_cmd_read,
  output logic [aon_pkg::DW-1:0]     o_rtc_cmd_wdata,
  input  wire                        i_rtc_rsp_valid,
  output logic                       o_rtc_rsp_ready,
  input  wire  [aon_pkg::DW-1:0]     i_rtc_rsp_rdata
);

  aon_pkg::split_state_e state_q;
  aon_pkg::split_state_e state_d;
  logic                  idle;
  logic                  sel_lclk;
  logic                  cmd_hsk;
  logic                  rsp_hsk;

  assign idle     = (state_q == aon_pkg::IDLE);
  assign sel_lclk = (i_cmd_addr[aon_pkg::AW-1:aon_pkg::LCLKGEN_REGION_LSB]
                     == aon_pkg::LCLKGEN_BASE[aon_pkg::AW-1:aon_pkg::LCLKGEN_REGION_LSB]);

  // Commands pass only from IDLE, which keeps a single one outstanding
  assign o_lclk_cmd_valid = idle & i_cmd_valid & sel_lclk;
  assign o_rtc_cmd_valid  = idle & i_cmd_valid & ~sel_lclk;
  assign o_cmd_ready      = idle & (sel_lclk ? i_lclk_cmd_ready : i_rtc_cmd_ready);
  assign cmd_hsk          = i_cmd_valid & o_cmd_ready;

  assign o_lclk_cmd_addr  = i_cmd_addr[aon_pkg::OFS_W-1:0];
  assign o_lclk_cmd_read  = i_cmd_read;
  assign o_lclk_cmd_wdata = i_cmd_wdata;
  assign o_rtc_cmd_addr   = i_cmd_addr[aon_pkg::OFS_W-1:0];
  assign o_rtc_cmd_read   = i_cmd_read;
  assign o_rtc_cmd_wdata  = i_cmd_wdata;

  assign o_lclk_rsp_ready = (state_q == aon_pkg::WAIT_LCLK) & i_rsp_ready;
  assign o_rtc_rsp_ready  = (state_q == aon_pkg::WAIT_RTC) & i_rsp_ready;

  always_comb begin
    o_rsp_valid = 1'b0;
    o_rsp_rdata = '0;
    case (state_q)
      aon_pkg::WAIT_LCLK: begin
        o_rsp_valid = i_lclk_rsp_valid;
        o_rsp_rdata = i_lclk_rsp_rdata;
      end
      aon_pkg::WAIT_RTC: begin
        o_rsp_valid = i_rtc_rsp_valid;
        o_rsp_rdata = i_rtc_rsp_rdata;
      end
      default: ;
    endcase
  end

  assign rsp_hsk = o_rsp_valid & i_rsp_ready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      aon_pkg::IDLE: begin
        if (cmd_hsk) begin
          state_d = sel_lclk ? aon_pkg::WAIT_LCLK : aon_pkg::WAIT_RTC;
        end
      end
      aon_pkg::WAIT_LCLK,
      aon_pkg::WAIT_RTC: begin
        if (rsp_hsk) begin
          state_d = aon_pkg::IDLE;
        end
      end
      default: state_d = aon_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= aon_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // A target takes a command only while no target still owes a response
  a_one_outstanding: assert property (@(posedge clk) disable iff (!i_rst_n)
    ((o_lclk_cmd_valid && i_lclk_cmd_ready) || (o_rtc_cmd_valid && i_rtc_cmd_ready))
      |-> !(i_lclk_rsp_valid || i_rtc_rsp_valid));

endmodule

`default_nettype wire

//--- src/aon_lclkgen_regs.sv
`timescale 1ns/1ns
`default_nettype none

module aon_lclkgen_regs (
  input  wire                        clk,
  input  wire                        i_rst_n,
  input  wire                        i_cmd_valid,
  output logic                       o_cmd_ready,
  input  wire  [aon_pkg::OFS_W-1:0]  i_cmd_addr,
  input  wire                        i_cmd_read,
  input  wire  [aon_pkg::DW-1:0]     i_cmd_wdata,
  output logic                       o_rsp_valid,
  input  wire                        i_rsp_ready,
  output logic [aon_pkg::DW-1:0]     o_rsp_rdata,
  output logic                       o_lfxoscen
);

  aon_pkg::bus_op_e       cmd_op;
  logic                   cmd_hsk;
  logic                   cfg_sel;
  logic                   lfxoscen_q;
  logic [aon_pkg::DW-1:0] rd_data;

  assign cmd_op      = i_cmd_read ? aon_pkg::OP_READ : aon_pkg::OP_WRITE;
  assign o_cmd_ready = ~o_rsp_valid;  // One response in flight at most
  assign cmd_hsk     = i_cmd_valid & o_cmd_ready;
  assign cfg_sel     = (i_cmd_addr == aon_pkg::LFXOSCCFG_OFS);

  always_comb begin
    rd_data = '0;
    if (cfg_sel) begin
      rd_data[aon_pkg::LFXOSCEN_BIT] = lfxoscen_q;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      lfxoscen_q <= aon_pkg::LFXOSCEN_RST;
    end else if (cmd_hsk && cfg_sel && cmd_op == aon_pkg::OP_WRITE) begin
      lfxoscen_q <= i_cmd_wdata[aon_pkg::LFXOSCEN_BIT];
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rsp_valid <= 1'b0;
    end else if (cmd_hsk) begin
      o_rsp_valid <= 1'b1;
    end else if (i_rsp_ready) begin
      o_rsp_valid <= 1'b0;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk) begin
    if (cmd_hsk) begin
      o_rsp_rdata <= (cmd_op == aon_pkg::OP_READ) ? rd_data : '0;
    end
  end

  assign o_lfxoscen = lfxoscen_q;

endmodule

`default_nettype wire

//--- src/aon_rtc_regs.sv
`timescale 1ns/1ns
`default_nettype none

module aon_rtc_regs (
  input  wire                        clk,
  input  wire                        i_rst_n,
  input  wire                        i_cmd_valid,
  output logic                       o_cmd_ready,
  input  wire  [aon_pkg::OFS_W-1:0]  i_cmd_addr,
  input  wire                        i_cmd_read,
  input  wire  [aon_pkg::DW-1:0]     i_cmd_wdata,
  output logic                       o_rsp_valid,
  input  wire                        i_rsp_ready,
  output logic [aon_pkg::DW-1:0]     o_rsp_rdata,
  output logic                       o_rtc_irq
);

  aon_pkg::bus_op_e       cmd_op;
  logic                   cmd_hsk;
  logic                   wr_hsk;
  logic                   en_q;
  logic                   ip_q;
  logic [aon_pkg::DW-1:0] count_q;
  logic [aon_pkg::DW-1:0] cmp_q;
  logic [aon_pkg::DW-1:0] rd_data;

  assign cmd_op      = i_cmd_read ? aon_pkg::OP_READ : aon_pkg::OP_WRITE;
  assign o_cmd_ready = ~o_rsp_valid;
  assign cmd_hsk     = i_cmd_valid & o_cmd_ready;
  assign wr_hsk      = cmd_hsk & (cmd_op == aon_pkg::OP_WRITE);

  always_comb begin
    rd_data = '0;
    case (i_cmd_addr)
      aon_pkg::RTC_CTRL_OFS:  rd_data[aon_pkg::RTC_EN_BIT] = en_q;
      aon_pkg::RTC_COUNT_OFS: rd_data = count_q;
      aon_pkg::RTC_CMP_OFS:   rd_data = cmp_q;
      aon_pkg::RTC_IP_OFS:    rd_data[aon_pkg::RTC_IP_BIT] = ip_q;
      default: ;  // Unmapped reads as zero
    endcase
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      en_q    <= 1'b0;
      count_q <= '0;
      cmp_q   <= aon_pkg::RTC_CMP_RST;
      ip_q    <= 1'b0;
    end else begin
      if (wr_hsk && i_cmd_addr == aon_pkg::RTC_CTRL_OFS) begin
        en_q <= i_cmd_wdata[aon_pkg::RTC_EN_BIT];
      end
      if (wr_hsk && i_cmd_addr == aon_pkg::RTC_COUNT_OFS) begin
        count_q <= i_cmd_wdata;  // Load wins over the tick
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr_hsk && i_cmd_addr == aon_pkg::RTC_CMP_OFS) begin
        cmp_q <= i_cmd_wdata;
      end
      // Sticky pending, write one to clear
      if (wr_hsk && i_cmd_addr == aon_pkg::RTC_IP_OFS && i_cmd_wdata[aon_pkg::RTC_IP_BIT]) begin
        ip_q <= 1'b0;
      end else if (count_q == cmp_q) begin
        ip_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rsp_valid <= 1'b0;
    end else if (cmd_hsk) begin
      o_rsp_valid <= 1'b1;
    end else if (i_rsp_ready) begin
      o_rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_hsk) begin
      o_rsp_rdata <= (cmd_op == aon_pkg::OP_READ) ? rd_data : '0;
    end
  end

  assign o_rtc_irq = ip_q;

  a_rsp_after_cmd: assert property (@(posedge clk) disable iff (!i_rst_n)
    $rose(o_rsp_valid) |-> $past(i_cmd_valid && o_cmd_ready));

endmodule

`default_nettype wire

//--- src/aon_icb_top.sv
`timescale 1ns/1ns
`default_nettype none

module aon_icb_top (
  input  wire                     clk,
  input  wire                     i_rst_n,
  input  wire                     i_aon_iso,
  input  wire                     i_cmd_valid,
  output logic                    o_cmd_ready,
  input  wire  [aon_pkg::AW-1:0]  i_cmd_addr,
  input  wire                     i_cmd_read,
  input  wire  [aon_pkg::DW-1:0]  i_cmd_wdata,
  output logic                    o_rsp_valid,
  input  wire                     i_rsp_ready,
  output logic [aon_pkg::DW-1:0]  o_rsp_rdata,
  output logic                    o_lfxoscen,
  output logic                    o_rtc_irq
);

  logic                      slc_cmd_valid;
  logic                      slc_cmd_ready;
  logic [aon_pkg::AW-1:0]    slc_cmd_addr;
  logic                      slc_cmd_read;
  logic [aon_pkg::DW-1:0]    slc_cmd_wdata;
  logic                      slc_rsp_ready;

  logic                      lclk_cmd_valid;
  logic                      lclk_cmd_ready;
  logic [aon_pkg::OFS_W-1:0] lclk_cmd_addr;
  logic                      lclk_cmd_read;
  logic [aon_pkg::DW-1:0]    lclk_cmd_wdata;
  logic                      lclk_rsp_valid;
  logic                      lclk_rsp_ready;
  logic [aon_pkg::DW-1:0]    lclk_rsp_rdata;

  logic                      rtc_cmd_valid;
  logic                      rtc_cmd_ready;
  logic [aon_pkg::OFS_W-1:0] rtc_cmd_addr;
  logic                      rtc_cmd_read;
  logic [aon_pkg::DW-1:0]    rtc_cmd_wdata;
  logic                      rtc_rsp_valid;
  logic                      rtc_rsp_ready;
  logic [aon_pkg::DW-1:0]    rtc_rsp_rdata;

  aon_icb_iso_slice u_iso_slice (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_aon_iso       (i_aon_iso),
    .i_cmd_valid     (i_cmd_valid),
    .o_cmd_ready     (o_cmd_ready),
    .i_cmd_addr      (i_cmd_addr),
    .i_cmd_read      (i_cmd_read),
    .i_cmd_wdata     (i_cmd_wdata),
    .i_rsp_ready     (i_rsp_ready),
    .o_slc_cmd_valid (slc_cmd_valid),
    .i_slc_cmd_ready (slc_cmd_ready),
    .o_slc_cmd_addr  (slc_cmd_addr),
    .o_slc_cmd_read  (slc_cmd_read),
    .o_slc_cmd_wdata (slc_cmd_wdata),
    .o_slc_rsp_ready (slc_rsp_ready)
  );

  // Response side goes out unisolated
  aon_icb_split u_split (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_cmd_valid      (slc_cmd_valid),
    .o_cmd_ready      (slc_cmd_ready),
    .i_cmd_addr       (slc_cmd_addr),
    .i_cmd_read       (slc_cmd_read),
    .i_cmd_wdata      (slc_cmd_wdata),
    .o_rsp_valid      (o_rsp_valid),
    .i_rsp_ready      (slc_rsp_ready),
    .o_rsp_rdata      (o_rsp_rdata),
    .o_lclk_cmd_valid (lclk_cmd_valid),
    .i_lclk_cmd_ready (lclk_cmd_ready),
    .o_lclk_cmd_addr  (lclk_cmd_addr),
    .o_lclk_cmd_read  (lclk_cmd_read),
    .o_lclk_cmd_wdata (lclk_cmd_wdata),
    .i_lclk_rsp_valid (lclk_rsp_valid),
    .o_lclk_rsp_ready (lclk_rsp_ready),
    .i_lclk_rsp_rdata (lclk_rsp_rdata),
    .o_rtc_cmd_valid  (rtc_cmd_valid),
    .i_rtc_cmd_ready  (rtc_cmd_ready),
    .o_rtc_cmd_addr   (rtc_cmd_addr),
    .o_rtc_cmd_read   (rtc_cmd_read),
    .o_rtc_cmd_wdata  (rtc_cmd_wdata),
    .i_rtc_rsp_valid  (rtc_rsp_valid),
    .o_rtc_rsp_ready  (rtc_rsp_ready),
    .i_rtc_rsp_rdata  (rtc_rsp_rdata)
  );

  aon_lclkgen_regs u_lclkgen_regs (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (lclk_cmd_valid),
    .o_cmd_ready (lclk_cmd_ready),
    .i_cmd_addr  (lclk_cmd_addr),
    .i_cmd_read  (lclk_cmd_read),
    .i_cmd_wdata (lclk_cmd_wdata),
    .o_rsp_valid (lclk_rsp_valid),
    .i_rsp_ready (lclk_rsp_ready),
    .o_rsp_rdata (lclk_rsp_rdata),
    .o_lfxoscen  (o_lfxoscen)
  );

  aon_rtc_regs u_rtc_regs (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (rtc_cmd_valid),
    .o_cmd_ready (rtc_cmd_ready),
    .i_cmd_addr  (rtc_cmd_addr),
    .i_cmd_read  (rtc_cmd_read),
    .i_cmd_wdata (rtc_cmd_wdata),
    .o_rsp_valid (rtc_rsp_valid),
    .i_rsp_ready (rtc_rsp_ready),
    .o_rsp_rdata (rtc_rsp_rdata),
    .o_rtc_irq   (o_rtc_irq)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;  // 20 ns period
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (2) @(posedge o_clk);
    #2 o_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
  input  wire        i_clk,
  input  wire        i_rst_n,
  input  wire        i_cmd_ready,
  input  wire        i_rsp_valid,
  input  wire        i_rsp_ready,
  input  wire [31:0] i_rsp_rdata,
  input  wire        i_lfxoscen,
  input  wire        i_rtc_irq,
  input  wire [31:0] i_exp_tag,   // Bumped once per command the host issues
  input  wire        i_exp_read,
  input  wire [14:0] i_exp_addr,
  input  wire [31:0] i_exp_data,
  input  wire [1:0]  i_exp_irq,   // 2 leaves o_rtc_irq unchecked
  output int         o_chk_cnt,
  output int         o_err_cnt
);

  logic        q_read[$];
  logic [14:0] q_addr[$];
  logic [31:0] q_data[$];
  logic [1:0]  q_irq[$];
  logic [31:0] seen_tag = '0;
  logic        rst_checked = 1'b0;
  logic        held = 1'b0;
  logic [31:0] held_rdata = '0;
  int          chk_cnt = 0;
  int          err_cnt = 0;

  assign o_chk_cnt = chk_cnt;
  assign o_err_cnt = err_cnt;

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t %s expected %08h got %08h", $time, name, exp, got);
    end
  endtask

  // Sampled mid-cycle, a transfer happens at the next rising edge
  always @(negedge i_clk) begin
    if (i_rst_n) begin
      if (!rst_checked) begin
        compare_value("o_rsp_valid", 32'd0, 32'(i_rsp_valid));
        compare_value("o_cmd_ready", 32'd1, 32'(i_cmd_ready));
        compare_value("o_rtc_irq", 32'd0, 32'(i_rtc_irq));
        compare_value("o_lfxoscen", 32'd1, 32'(i_lfxoscen));
        rst_checked = 1'b1;
      end
      if (i_exp_tag != seen_tag) begin
        q_read.push_back(i_exp_read);
        q_addr.push_back(i_exp_addr);
        q_data.push_back(i_exp_data);
        q_irq.push_back(i_exp_irq);
        seen_tag = i_exp_tag;
      end
      if (held) begin
        if (!i_rsp_valid) begin
          err_cnt++;
          $display("%0t: o_rsp_valid dropped before the response was taken", $time);
        end else begin
          compare_value("o_rsp_rdata while stalled", held_rdata, i_rsp_rdata);
        end
      end
      if (i_rsp_valid && i_rsp_ready) begin
        if (q_read.size() == 0) begin
          err_cnt++;
          $display("%0t: a response arrived with no command outstanding", $time);
        end else begin
          if (q_read[0]) begin
            compare_value("o_rsp_rdata", q_data[0], i_rsp_rdata);
          end
          if (q_irq[0] != 2'd2) begin
            compare_value("o_rtc_irq", 32'(q_irq[0]), 32'(i_rtc_irq));
          end
          // Oscillator enable pin must agree with the register bit
          if (q_read[0] && q_addr[0] == aon_pkg::LCLKGEN_BASE) begin
            compare_value("o_lfxoscen", 32'(q_data[0][30]), 32'(i_lfxoscen));
          end
          q_read.delete(0);
          q_addr.delete(0);
          q_data.delete(0);
          q_irq.delete(0);
        end
      end
      held       = i_rsp_valid && !i_rsp_ready;
      held_rdata = i_rsp_rdata;
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_aon_icb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_aon_icb_top;

  localparam int CMD_TIMEOUT = 200;
  localparam int IRQ_TIMEOUT = 100;
  localparam int ISO_WINDOW  = 20;

  logic        clk;
  logic        rst_n;
  logic        aon_iso;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [14:0] cmd_addr;
  logic        cmd_read;
  logic [31:0] cmd_wdata;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [31:0] rsp_rdata;
  logic        lfxoscen;
  logic        rtc_irq;
  logic [31:0] exp_tag;
  logic        exp_read;
  logic [14:0] exp_addr;
  logic [31:0] exp_data;
  logic [1:0]  exp_irq;
  int          chk_cnt;
  int          err_cnt;
  int          fail_cnt;
  logic        abort;
  logic        rsp_owed;
  integer      seed;
  integer      fd;

  tb_clkgen u_clkgen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  aon_icb_top aon_icb_top_i (
    .clk         (clk),
    .i_rst_n     (rst_n),
    .i_aon_iso   (aon_iso),
    .i_cmd_valid (cmd_valid),
    .o_cmd_ready (cmd_ready),
    .i_cmd_addr  (cmd_addr),
    .i_cmd_read  (cmd_read),
    .i_cmd_wdata (cmd_wdata),
    .o_rsp_valid (rsp_valid),
    .i_rsp_ready (rsp_ready),
    .o_rsp_rdata (rsp_rdata),
    .o_lfxoscen  (lfxoscen),
    .o_rtc_irq   (rtc_irq)
  );

  tb_checker u_checker (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_cmd_ready (cmd_ready),
    .i_rsp_valid (rsp_valid),
    .i_rsp_ready (rsp_ready),
    .i_rsp_rdata (rsp_rdata),
    .i_lfxoscen  (lfxoscen),
    .i_rtc_irq   (rtc_irq),
    .i_exp_tag   (exp_tag),
    .i_exp_read  (exp_read),
    .i_exp_addr  (exp_addr),
    .i_exp_data  (exp_data),
    .i_exp_irq   (exp_irq),
    .o_chk_cnt   (chk_cnt),
    .o_err_cnt   (err_cnt)
  );

  task automatic next_drive_slot;
    @(posedge clk);
    #2;
  endtask

  task automatic flag_failure(input string msg);
    $display("%0t: %s", $time, msg);
    fail_cnt++;
    abort = 1'b1;
  endtask

  task automatic wait_reset_release;
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      flag_failure("reset was never released");
    end
    #2;
  endtask

  task automatic issue_cmd(input logic rd, input logic [14:0] addr,
                           input logic [31:0] data, input logic [1:0] irq);
    int n;
    exp_read  = rd;
    exp_addr  = addr;
    exp_data  = data;
    exp_irq   = irq;
    exp_tag   = exp_tag + 32'd1;
    cmd_valid = 1'b1;
    cmd_addr  = addr;
    cmd_read  = rd;
    cmd_wdata = rd ? '0 : data;
    n = 0;
    @(negedge clk);
    while (!cmd_ready && n < CMD_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_ready) begin
      flag_failure($sformatf("command not accepted within %0d cycles", CMD_TIMEOUT));
    end
    next_drive_slot();  // Transfer edge
    cmd_valid = 1'b0;
  endtask

  task automatic take_rsp;
    int n;
    int stall;
    n = 0;
    @(negedge clk);
    while (!rsp_valid && n < CMD_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!rsp_valid) begin
      flag_failure($sformatf("no response within %0d cycles", CMD_TIMEOUT));
    end else begin
      stall = $unsigned($random(seed)) % 4;
      next_drive_slot();
      repeat (stall) next_drive_slot();
      rsp_ready = 1'b1;
      next_drive_slot();
      rsp_ready = 1'b0;
    end
  endtask

  task automatic drain_owed_rsp;
    if (rsp_owed && !abort) begin
      take_rsp();
    end
    rsp_owed = 1'b0;
  endtask

  // Host side is clamped, so nothing may come back
  task automatic isolated_cmd(input logic rd, input logic [14:0] addr,
                              input logic [31:0] data);
    int n;
    aon_iso   = 1'b1;
    cmd_valid = 1'b1;
    cmd_addr  = addr;
    cmd_read  = rd;
    cmd_wdata = data;
    next_drive_slot();
    cmd_valid = 1'b0;
    n = 0;
    while (!rsp_valid && n < ISO_WINDOW) begin
      @(negedge clk);
      n++;
    end
    if (rsp_valid) begin
      flag_failure("a response appeared for a command sent under isolation");
    end
    next_drive_slot();
    aon_iso = 1'b0;
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while (rtc_irq !== level && n < IRQ_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (rtc_irq !== level) begin
      flag_failure($sformatf("o_rtc_irq did not reach %0d within %0d cycles",
                             level, IRQ_TIMEOUT));
    end
    next_drive_slot();
  endtask

  task automatic run_line(input logic [7:0] op, input logic iso, input logic [14:0] addr,
                          input logic [31:0] data, input logic [1:0] irq);
    if (op == "I") begin
      drain_owed_rsp();
      wait_irq(irq[0]);
    end else if ((op == "W" || op == "R") && iso) begin
      drain_owed_rsp();
      isolated_cmd(op == "R", addr, data);
    end else if (op == "W" || op == "R") begin
      // Next command goes in while the previous response is still pending
      if (rsp_owed) begin
        fork
          issue_cmd(op == "R", addr, data, irq);
          take_rsp();
        join
      end else begin
        issue_cmd(op == "R", addr, data, irq);
      end
      rsp_owed = !abort;
    end else begin
      flag_failure("unknown operation in the test data file");
    end
  endtask

  initial begin
    string       line;
    logic [7:0]  op;
    logic        iso;
    logic [14:0] addr;
    logic [31:0] data;
    logic [1:0]  irq;
    int          rc;
    aon_iso   = 1'b0;
    cmd_valid = 1'b0;
    cmd_addr  = '0;
    cmd_read  = 1'b0;
    cmd_wdata = '0;
    rsp_ready = 1'b0;
    exp_tag   = '0;
    exp_read  = 1'b0;
    exp_addr  = '0;
    exp_data  = '0;
    exp_irq   = 2'd2;
    fail_cnt  = 0;
    abort     = 1'b0;
    rsp_owed  = 1'b0;
    seed      = 32'h7f33;
    fd = $fopen("testbench/aon_testdata.txt", "r");
    if (fd == 0) begin
      flag_failure("cannot open testbench/aon_testdata.txt");
    end
    wait_reset_release();
    while (!abort && !$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 0 && line.getc(0) != "#") begin
        rc = $sscanf(line, "%c %h %h %h %h", op, iso, addr, data, irq);
        if (rc == 5) begin
          run_line(op, iso, addr, data, irq);
        end
      end
    end
    drain_owed_rsp();
    if (fd != 0) begin
      $fclose(fd);
    end
    repeat (3) next_drive_slot();  // Let the checker see the last cycle
    $display("Checks: %0d, compare errors: %0d, other failures: %0d",
             chk_cnt, err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- aon_icb_top.f
src/aon_pkg.sv
src/aon_icb_iso_slice.sv
src/aon_icb_split.sv
src/aon_lclkgen_regs.sv
src/aon_rtc_regs.sv
src/aon_icb_top.sv
testbench/tb_clkgen.sv
testbench/tb_checker.sv
testbench/tb_aon_icb_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_aon_icb_top \
  -f aon_icb_top.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q ">>> FAIL" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"

//--- testbench/aon_testdata.txt
# Columns: op iso addr(hex) data(hex) irq, ops W write, R read, I wait for irq level
# For R the data column is the expected read data, irq 2 skips the irq check
R 0 200 40000000 0
W 0 200 00000000 0
R 0 200 00000000 0
R 0 204 00000000 0
W 0 048 12345678 0
R 0 048 12345678 0
W 0 050 cafe0000 0
R 0 050 cafe0000 0
W 0 040 00000000 0
R 0 040 00000000 0
R 0 044 00000000 0
R 0 058 00000000 0
W 0 048 00000010 0
W 0 050 00000030 0
W 0 040 00000001 0
R 0 040 00000001 0
I 0 000 00000000 1
R 0 058 00000001 1
W 0 040 00000000 1
W 0 058 00000001 0
R 0 058 00000000 0
W 1 200 40000000 0
R 0 200 00000000 0
W 1 048 00000030 0
R 0 058 00000000 0
R 1 050 00000030 0
R 0 050 00000030 0
R 0 040 00000000 0
R 0 200 00000000 0
